// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tbTop
FILELIST = vlog.f
OBJDIR = obj_dir
PASSTEXT = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none
module alu (
	input wire [3:0] aluOp,
	input wire [rvPkg::DataWidth-1:0] aluX,
	input wire [rvPkg::DataWidth-1:0] aluY,
	output logic [rvPkg::DataWidth-1:0] aluResult
);

	logic [4:0] shamt;

	assign shamt = aluY[4:0];

	always_comb
	begin
		aluResult = '0; // compares only set bit 0
		case (aluOp)
			rvPkg::AluAdd: aluResult = aluX + aluY;
			rvPkg::AluSub: aluResult = aluX - aluY;
			rvPkg::AluSll: aluResult = aluX << shamt;
			rvPkg::AluSrl: aluResult = aluX >> shamt;
			rvPkg::AluSra: aluResult = $signed(aluX) >>> shamt;
			rvPkg::AluXor: aluResult = aluX ^ aluY;
			rvPkg::AluOr: aluResult = aluX | aluY;
			rvPkg::AluAnd: aluResult = aluX & aluY;
			rvPkg::AluSlt: aluResult[0] = $signed(aluX) < $signed(aluY);
			rvPkg::AluSltu: aluResult[0] = aluX < aluY;
			rvPkg::AluEq: aluResult[0] = aluX == aluY;
			rvPkg::AluNe: aluResult[0] = aluX != aluY;
			rvPkg::AluGe: aluResult[0] = $signed(aluX) >= $signed(aluY);
			rvPkg::AluGeu: aluResult[0] = aluX >= aluY;
			default: aluResult = '0;
		endcase
	end

endmodule
`default_nettype wire

// File: source/coreTop.sv
`timescale 1ns/1ps
`default_nettype none
module coreTop (
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire rvPkg::instrWord instr,
	output logic [rvPkg::AddrWidth-1:0] pc,
	output logic retireValid,
	output logic [4:0] retireReg,
	output logic [rvPkg::DataWidth-1:0] retireData
);

	logic [4:0] rs1, rs2, rd;
	logic [2:0] funct3;
	logic funct7bit;
	logic [3:0] aluOp;
	logic [1:0] pcOp;
	logic regWrite;
	logic memWrite;
	logic [3:0] memByteEnable;
	logic [rvPkg::DataWidth-1:0] imm, regData1, regData2, memReadData;
	logic [rvPkg::DataWidth-1:0] aluX, aluY, aluResult;
	logic [rvPkg::DataWidth-1:0] regWriteData, memWriteData;
	logic [rvPkg::AddrWidth-1:0] pcTarget, memAddr;

	instrFields fields (.*);
	decode dec (.*);
	alu aluUnit (.*);
	programCounter pcReg (.pcOffset(imm), .*);
	registerFile regs (.*);
	dataMemory dmem (.*);

	always_ff @(posedge clk)
	begin
		if (reset)
			retireValid <= 1'b0;
		else
			retireValid <= regWrite; // already excludes x0
	end

	always_ff @(posedge clk)
	begin
		retireReg <= rd;
		retireData <= regWriteData;
	end

endmodule
`default_nettype wire

// File: source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none
module dataMemory (
	input wire clk,
	input wire memWrite,
	input wire [3:0] memByteEnable,
	input wire [rvPkg::AddrWidth-1:0] memAddr,
	input wire [rvPkg::DataWidth-1:0] memWriteData,
	output logic [rvPkg::DataWidth-1:0] memReadData
);

	logic [rvPkg::DataWidth-1:0] mem [rvPkg::MemWords];
	logic [rvPkg::MemIndexWidth-1:0] index;

	assign index = memAddr[rvPkg::MemIndexWidth+1:2]; // word address, wraps

	always_ff @(posedge clk)
	begin
		if (memWrite)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (memByteEnable[lane])
					mem[index][lane*8 +: 8] <= memWriteData[lane*8 +: 8];
			end
		end
	end

	assign memReadData = mem[index];

endmodule
`default_nettype wire

// File: source/decode.sv
`timescale 1ns/1ps
`default_nettype none
module decode (
	input wire instrValid,
	input wire rvPkg::instrWord instr,
	input wire [2:0] funct3,
	input wire funct7bit,
	input wire [rvPkg::DataWidth-1:0] imm,
	input wire [rvPkg::DataWidth-1:0] regData1,
	input wire [rvPkg::DataWidth-1:0] regData2,
	input wire [rvPkg::DataWidth-1:0] memReadData,
	input wire [rvPkg::AddrWidth-1:0] pc,
	input wire [rvPkg::DataWidth-1:0] aluResult,
	output logic [3:0] aluOp,
	output logic [rvPkg::DataWidth-1:0] aluX,
	output logic [rvPkg::DataWidth-1:0] aluY,
	output logic [1:0] pcOp,
	output logic [rvPkg::AddrWidth-1:0] pcTarget,
	output logic regWrite,
	output logic [rvPkg::DataWidth-1:0] regWriteData,
	output logic memWrite,
	output logic [3:0] memByteEnable,
	output logic [rvPkg::AddrWidth-1:0] memAddr,
	output logic [rvPkg::DataWidth-1:0] memWriteData
);

	logic [6:0] opcode;
	logic isReg;
	logic wantRegWrite;
	logic wantMemWrite;
	logic [rvPkg::DataWidth-1:0] loadShifted;
	logic [rvPkg::DataWidth-1:0] loadData;
	logic [rvPkg::AddrWidth-1:0] linkAddr;

	assign opcode = instr.r.opcode;
	assign isReg = opcode == rvPkg::OpReg;
	assign memAddr = aluResult;
	assign pcTarget = aluResult; // jalr rs1 + imm
	assign linkAddr = pc + 32'd4;
	assign loadShifted = memReadData >> {aluResult[1:0], 3'b000}; // selected lane to bit 0

	always_comb
	begin
		case (funct3)
			3'd0: loadData = {{24{loadShifted[7]}}, loadShifted[7:0]};
			3'd1: loadData = {{16{loadShifted[15]}}, loadShifted[15:0]};
			3'd4: loadData = {24'b0, loadShifted[7:0]};
			3'd5: loadData = {16'b0, loadShifted[15:0]};
			default: loadData = memReadData; // lw
		endcase
	end

	// operand and ALU select, independent of the ALU result
	always_comb
	begin
		aluOp = rvPkg::AluAdd;
		aluX = regData1;
		aluY = imm;
		case (opcode)
			rvPkg::OpReg, rvPkg::OpImm:
			begin
				if (isReg)
					aluY = regData2;
				case (funct3)
					3'd0: aluOp = (funct7bit && isReg) ? rvPkg::AluSub : rvPkg::AluAdd;
					3'd1: aluOp = rvPkg::AluSll;
					3'd2: aluOp = rvPkg::AluSlt;
					3'd3: aluOp = rvPkg::AluSltu;
					3'd4: aluOp = rvPkg::AluXor;
					3'd5: aluOp = funct7bit ? rvPkg::AluSra : rvPkg::AluSrl;
					3'd6: aluOp = rvPkg::AluOr;
					default: aluOp = rvPkg::AluAnd;
				endcase
			end
			rvPkg::OpBranch:
			begin
				aluY = regData2;
				case (funct3)
					3'd0: aluOp = rvPkg::AluEq;
					3'd1: aluOp = rvPkg::AluNe;
					3'd4: aluOp = rvPkg::AluSlt;
					3'd5: aluOp = rvPkg::AluGe;
					3'd6: aluOp = rvPkg::AluSltu;
					3'd7: aluOp = rvPkg::AluGeu;
					default: aluOp = rvPkg::AluAdd;
				endcase
			end
			rvPkg::OpAuipc: aluX = pc;
			default: aluX = regData1; // loads, stores, jalr
		endcase
	end

	always_comb
	begin
		pcOp = rvPkg::PcAdd4;
		regWriteData = aluResult;
		memWriteData = regData2;
		memByteEnable = 4'b0000;
		wantRegWrite = 1'b0;
		wantMemWrite = 1'b0;
		case (opcode)
			rvPkg::OpReg, rvPkg::OpImm, rvPkg::OpAuipc: wantRegWrite = 1'b1;
			rvPkg::OpLoad:
			begin
				regWriteData = loadData;
				wantRegWrite = 1'b1;
			end
			rvPkg::OpStore:
			begin
				case (funct3[1:0])
					2'd0:
					begin
						memWriteData = {4{regData2[7:0]}};
						memByteEnable = 4'b0001 << aluResult[1:0];
					end
					2'd1:
					begin
						memWriteData = {2{regData2[15:0]}};
						memByteEnable = aluResult[1] ? 4'b1100 : 4'b0011;
					end
					default: memByteEnable = 4'b1111;
				endcase
				wantMemWrite = 1'b1;
			end
			rvPkg::OpBranch:
			begin
				// funct3 2 and 3 are not branches
				if (aluResult[0] && funct3[2:1] != 2'b01)
					pcOp = rvPkg::PcAddImm;
			end
			rvPkg::OpJal, rvPkg::OpJalr:
			begin
				pcOp = (opcode == rvPkg::OpJal) ? rvPkg::PcAddImm : rvPkg::PcSet;
				regWriteData = linkAddr;
				wantRegWrite = 1'b1;
			end
			rvPkg::OpLui:
			begin
				regWriteData = imm;
				wantRegWrite = 1'b1;
			end
			default: wantRegWrite = 1'b0; // unknown, just step
		endcase
		if (!instrValid)
			pcOp = rvPkg::PcHold;
		regWrite = wantRegWrite && instrValid && instr.r.rd != 5'd0;
		memWrite = wantMemWrite && instrValid;
	end

endmodule
`default_nettype wire

// File: source/instrFields.sv
`timescale 1ns/1ps
`default_nettype none
module instrFields (
	input wire rvPkg::instrWord instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [2:0] funct3,
	output logic funct7bit,
	output logic [rvPkg::DataWidth-1:0] imm
);

	assign rs1 = instr.r.rs1;
	assign rs2 = instr.r.rs2;
	assign rd = instr.r.rd;
	assign funct3 = instr.r.funct3;
	assign funct7bit = instr.r.funct7[5]; // sub, sra, srai

	always_comb
	begin
		case (instr.r.opcode)
			rvPkg::OpLoad, rvPkg::OpImm, rvPkg::OpJalr:
				imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
			rvPkg::OpStore:
				imm = {{20{instr.s.immHigh[6]}}, instr.s.immHigh, instr.s.immLow};
			rvPkg::OpBranch:
				imm = {{20{instr.b.immSign}}, instr.b.immBit11, instr.b.immMid,
					instr.b.immLow, 1'b0};
			rvPkg::OpLui, rvPkg::OpAuipc:
				imm = {instr.uj.imm20, 12'b0};
			rvPkg::OpJal: // imm[20|10:1|11|19:12]
				imm = {{12{instr.uj.imm20[19]}}, instr.uj.imm20[7:0], instr.uj.imm20[8],
					instr.uj.imm20[18:9], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule
`default_nettype wire

// File: source/programCounter.sv
`timescale 1ns/1ps
`default_nettype none
module programCounter (
	input wire clk,
	input wire reset,
	input wire [1:0] pcOp,
	input wire [rvPkg::AddrWidth-1:0] pcOffset,
	input wire [rvPkg::AddrWidth-1:0] pcTarget,
	output logic [rvPkg::AddrWidth-1:0] pc
);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else
		begin
			case (pcOp)
				rvPkg::PcAdd4: pc <= pc + 32'd4;
				rvPkg::PcAddImm: pc <= pc + pcOffset; // branch taken, jal
				rvPkg::PcSet: pc <= {pcTarget[rvPkg::AddrWidth-1:1], 1'b0}; // jalr
				default: pc <= pc;
			endcase
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule
`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none
module registerFile (
	input wire clk,
	input wire reset,
	input wire [4:0] rs1,
	input wire [4:0] rs2,
	input wire regWrite,
	input wire [4:0] rd,
	input wire [rvPkg::DataWidth-1:0] regWriteData,
	output logic [rvPkg::DataWidth-1:0] regData1,
	output logic [rvPkg::DataWidth-1:0] regData2
);

	logic [rvPkg::DataWidth-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (regWrite && rd != 5'd0)
			regs[rd] <= regWriteData; // x0 stays zero
	end

	assign regData1 = regs[rs1];
	assign regData2 = regs[rs2];

	// decode must already have dropped x0 writes
	noZeroWrite: assert property (@(posedge clk) disable iff (reset) regWrite |-> rd != 5'd0)
		else $error("register write to x0 reached the register file");

endmodule
`default_nettype wire

// File: source/rvPkg.sv
`default_nettype none
package rvPkg;
	localparam int DataWidth = 32;
	localparam int AddrWidth = 32;
	localparam int MemWords = 256;
	localparam int MemIndexWidth = $clog2(MemWords);

	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal = 7'b1101111;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpAuipc = 7'b0010111;

	localparam logic [3:0] AluAdd = 4'd0;
	localparam logic [3:0] AluSub = 4'd1;
	localparam logic [3:0] AluSll = 4'd2;
	localparam logic [3:0] AluSlt = 4'd3;
	localparam logic [3:0] AluSltu = 4'd4;
	localparam logic [3:0] AluXor = 4'd5;
	localparam logic [3:0] AluSrl = 4'd6;
	localparam logic [3:0] AluSra = 4'd7;
	localparam logic [3:0] AluOr = 4'd8;
	localparam logic [3:0] AluAnd = 4'd9;
	localparam logic [3:0] AluEq = 4'd10;
	localparam logic [3:0] AluNe = 4'd11;
	localparam logic [3:0] AluGe = 4'd12;
	localparam logic [3:0] AluGeu = 4'd13;

	localparam logic [1:0] PcAdd4 = 2'd0;
	localparam logic [1:0] PcAddImm = 2'd1;
	localparam logic [1:0] PcSet = 2'd2;
	localparam logic [1:0] PcHold = 2'd3;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] immHigh;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLow;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic immSign; // imm[12]
			logic [5:0] immMid; // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] immLow; // imm[4:1]
			logic immBit11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm20;
			logic [4:0] rd;
			logic [6:0] opcode;
		} uj;
	} instrWord;
endpackage
`default_nettype wire

// File: verification/tbChecker.sv
`timescale 1ns/1ps
`default_nettype none
module tbChecker (
	input wire clk,
	input wire retireValid,
	input wire [4:0] retireReg,
	input wire [31:0] retireData,
	input wire [31:0] pc
);

	localparam int RetireTimeout = 3; // cycles to wait for a retire

	int testCount = 0;
	int failCount = 0;
	int errorCount = 0;

	task automatic checkRow(input string name, input logic expRetire, input logic [4:0] expReg,
		input logic [31:0] expData, input logic [31:0] expPc);
		int waited;
		int errorsBefore;
		logic seen;
		errorsBefore = errorCount;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < RetireTimeout)
		begin
			@(negedge clk); // outputs settled mid cycle
			waited++;
			if (retireValid)
				seen = 1'b1;
		end
		if (expRetire && !seen)
		begin
			$display("%s: no register write retired within %0d cycles", name, RetireTimeout);
			errorCount++;
		end
		else if (!expRetire && seen)
		begin
			$display("%s: unexpected register write retired to x%0d", name, retireReg);
			errorCount++;
		end
		else if (seen)
		begin
			if (retireReg !== expReg)
			begin
				$display("error at %0d ns: retireReg is %0d, expected %0d", $time, retireReg,
					expReg);
				errorCount++;
			end
			if (retireData !== expData)
			begin
				$display("error at %0d ns: retireData is %h, expected %h", $time, retireData,
					expData);
				errorCount++;
			end
		end
		if (pc !== expPc)
		begin
			$display("error at %0d ns: pc is %h, expected %h", $time, pc, expPc);
			errorCount++;
		end
		testCount++;
		if (errorCount != errorsBefore)
			failCount++;
		$display("test %0d %s: %s", testCount, name,
			(errorCount == errorsBefore) ? "ok" : "failed");
	endtask

	task automatic printSummary();
		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
	endtask

endmodule
`default_nettype wire

// File: verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none
module tbClock (
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#4 clk = ~clk; // 8 ns period

endmodule
`default_nettype wire

// File: verification/tbTop.sv
`timescale 1ns/1ps
`default_nettype none
module tbTop;
	localparam int MaxRows = 64;

	logic clk;
	logic reset;
	logic instrValid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic retireValid;
	logic [4:0] retireReg;
	logic [31:0] retireData;

	logic [31:0] rowInstr [MaxRows];
	logic rowRetire [MaxRows];
	logic [4:0] rowReg [MaxRows];
	logic [31:0] rowData [MaxRows];
	logic [31:0] rowPc [MaxRows];
	string rowName [MaxRows];
	int rowCount;

	logic [31:0] regModel [32];
	logic [7:0] memModel [256];
	logic [31:0] pcModel;
	logic [31:0] randState;

	logic [2:0] opF3 [10] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
	logic opF7 [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	string opNames [10] = '{"add", "sub", "slt", "sltu", "xor", "or", "and", "sll", "srl", "sra"};
	logic [2:0] brF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	string brNames [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};

	tbClock clockGen (.clk(clk));
	coreTop dut (.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .pc(pc),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData));
	tbChecker chk (.clk(clk), .retireValid(retireValid), .retireReg(retireReg),
		.retireData(retireData), .pc(pc));

	function automatic logic [31:0] nextRandom();
		randState = randState * 32'd1664525 + 32'd1013904223;
		return randState;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] encR(input logic [2:0] f3, input logic f7bit,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {(f7bit ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, rvPkg::OpReg};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::OpStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::OpBranch};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::OpJal};
	endfunction

	function automatic logic [31:0] regOpResult(input logic [2:0] f3, input logic f7bit,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] res;
		case (f3)
			3'd0: res = f7bit ? a - b : a + b;
			3'd1: res = a << b[4:0];
			3'd2: res = {31'b0, $signed(a) < $signed(b)};
			3'd3: res = {31'b0, a < b};
			3'd4: res = a ^ b;
			3'd5: res = a >> b[4:0];
			3'd6: res = a | b;
			default: res = a & b;
		endcase
		if (f3 == 3'd5 && f7bit)
			res = $signed(a) >>> b[4:0]; // sra fills with the sign bit
		return res;
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic addRow(input logic [31:0] word, input logic retire, input logic [4:0] rd,
		input logic [31:0] data, input logic [31:0] nextPc, input string name);
		rowInstr[rowCount] = word;
		rowRetire[rowCount] = retire;
		rowReg[rowCount] = rd;
		rowData[rowCount] = data;
		rowPc[rowCount] = nextPc;
		rowName[rowCount] = name;
		if (retire)
			regModel[rd] = data;
		pcModel = nextPc;
		rowCount++;
	endtask

	task automatic addStep(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] data,
		input string name);
		addRow(word, rd != 5'd0, rd, data, pcModel + 32'd4, name);
	endtask

	task automatic addStore(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] offset,
		input string name);
		logic [7:0] a;
		logic [31:0] v;
		a = 8'(regModel[14] + sext12(offset));
		v = regModel[rs2];
		for (int b = 0; b < (1 << f3); b++)
			memModel[a + 8'(b)] = v[b*8 +: 8]; // little endian bytes
		addRow(encS(offset, rs2, 5'd14, f3), 1'b0, 5'd0, 32'd0, pcModel + 32'd4, name);
	endtask

	task automatic addLoad(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] offset,
		input string name);
		logic [7:0] a;
		logic [31:0] w;
		logic [31:0] data;
		a = 8'(regModel[14] + sext12(offset));
		w = {memModel[a + 8'd3], memModel[a + 8'd2], memModel[a + 8'd1], memModel[a]};
		case (f3)
			3'd0: data = {{24{w[7]}}, w[7:0]};
			3'd1: data = {{16{w[15]}}, w[15:0]};
			3'd4: data = {24'b0, w[7:0]};
			3'd5: data = {16'b0, w[15:0]};
			default: data = w;
		endcase
		addStep(encI(offset, 5'd14, f3, rd, rvPkg::OpLoad), rd, data, name);
	endtask

	task automatic buildTable();
		logic [31:0] r;
		logic [31:0] off;
		logic [4:0] pairA [3];
		logic [4:0] pairB [3];
		pairA = '{5'd1, 5'd2, 5'd1};
		pairB = '{5'd2, 5'd1, 5'd1};
		rowCount = 0;
		pcModel = 32'd0;
		for (int i = 0; i < 32; i++)
			regModel[i] = 32'd0;
		r = nextRandom() | 32'h8000_0000; // x1 negative for sra
		addStep({r[31:12], 5'd1, rvPkg::OpLui}, 5'd1, {r[31:12], 12'b0}, "lui x1");
		r = nextRandom();
		addStep(encI(r[11:0], 5'd1, 3'd0, 5'd1, rvPkg::OpImm), 5'd1,
			regModel[1] + sext12(r[11:0]), "addi x1");
		r = nextRandom();
		addStep({r[31:12], 5'd2, rvPkg::OpLui}, 5'd2, {r[31:12], 12'b0}, "lui x2");
		r = nextRandom() | 32'd1; // nonzero shift amount
		addStep(encI(r[11:0], 5'd2, 3'd0, 5'd2, rvPkg::OpImm), 5'd2,
			regModel[2] + sext12(r[11:0]), "addi x2");
		for (int k = 0; k < 10; k++)
			addStep(encR(opF3[k], opF7[k], 5'(k + 3), 5'd1, 5'd2), 5'(k + 3),
				regOpResult(opF3[k], opF7[k], regModel[1], regModel[2]), opNames[k]);
		r = nextRandom();
		addStep({r[31:12], 5'd13, rvPkg::OpAuipc}, 5'd13, pcModel + {r[31:12], 12'b0},
			"auipc x13");
		addStep(encI(12'd64, 5'd0, 3'd0, 5'd14, rvPkg::OpImm), 5'd14, 32'd64, "addi x14");
		addStore(3'd2, 5'd1, 12'd0, "sw x1,0(x14)");
		addStore(3'd2, 5'd2, 12'd4, "sw x2,4(x14)");
		addStore(3'd1, 5'd2, 12'd2, "sh x2,2(x14)");
		addStore(3'd0, 5'd1, 12'd5, "sb x1,5(x14)");
		addLoad(3'd2, 5'd15, 12'd0, "lw x15,0(x14)");
		addLoad(3'd1, 5'd16, 12'd2, "lh x16,2(x14)");
		addLoad(3'd5, 5'd17, 12'd2, "lhu x17,2(x14)");
		addLoad(3'd0, 5'd18, 12'd5, "lb x18,5(x14)");
		addLoad(3'd4, 5'd19, 12'd5, "lbu x19,5(x14)");
		addLoad(3'd1, 5'd20, 12'd6, "lh x20,6(x14)");
		addLoad(3'd2, 5'd21, 12'd4, "lw x21,4(x14)");
		// each pair order gives one taken and one not taken case
		for (int k = 0; k < 6; k++)
			for (int p = 0; p < 3; p++)
			begin
				r = nextRandom();
				off = {27'b0, r[2:0], 2'b00} + 32'd8; // taken target never pc + 4
				addRow(encB(off[12:0], pairB[p], pairA[p], brF3[k]), 1'b0, 5'd0, 32'd0,
					branchTaken(brF3[k], regModel[pairA[p]], regModel[pairB[p]]) ?
					pcModel + off : pcModel + 32'd4,
					$sformatf("%s x%0d,x%0d", brNames[k], pairA[p], pairB[p]));
			end
		r = nextRandom();
		off = {{21{r[10]}}, r[10:2], 2'b00};
		addRow(encJ(off[20:0], 5'd22), 1'b1, 5'd22, pcModel + 32'd4, pcModel + off, "jal x22");
		r = nextRandom();
		addStep(encI({2'b00, r[9:4], 4'b0001}, 5'd0, 3'd0, 5'd24, rvPkg::OpImm), 5'd24,
			{22'b0, r[9:4], 4'b0001}, "addi x24"); // odd base, bit 0 cleared by jalr
		off = {25'b0, r[15:11], 2'b00};
		addRow(encI(off[11:0], 5'd24, 3'd0, 5'd23, rvPkg::OpJalr), 1'b1, 5'd23, pcModel + 32'd4,
			(regModel[24] + off) & ~32'd1, "jalr x23");
		r = nextRandom() | 32'd1; // nonzero, so a stray write would show
		addRow(encI(r[11:0], 5'd0, 3'd0, 5'd0, rvPkg::OpImm), 1'b0, 5'd0, 32'd0,
			pcModel + 32'd4, "addi x0");
		addStep(encR(3'd0, 1'b0, 5'd25, 5'd0, 5'd0), 5'd25, 32'd0, "add x25,x0,x0");
	endtask

	initial
	begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = 32'd0;
		randState = 32'hc193f92e;
		buildTable();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		chk.checkRow("reset", 1'b0, 5'd0, 32'd0, 32'd0);
		for (int i = 0; i < rowCount; i++)
		begin
			@(posedge clk);
			instr <= rowInstr[i];
			instrValid <= 1'b1;
			@(posedge clk);
			instrValid <= 1'b0; // one cycle strobe
			chk.checkRow(rowName[i], rowRetire[i], rowReg[i], rowData[i], rowPc[i]);
		end
		chk.printSummary();
		if (chk.errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
`default_nettype wire

// File: vlog.f
source/rvPkg.sv
source/instrFields.sv
source/alu.sv
source/programCounter.sv
source/registerFile.sv
source/dataMemory.sv
source/decode.sv
source/coreTop.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbTop.sv
